// ==== Bender.yml ====
package:
  name: matched_filter

sources:
  - logic/mfPkg.sv
  - logic/mfCoeffRegs.sv
  - logic/complexCorrelator.sv
  - logic/powerDetect.sv
  - logic/matchedFilter.sv
  - target: test
    files:
      - tests/matchedFilter_assert.sv
      - tests/matchedFilterTb.sv

// ==== logic/complexCorrelator.sv ====
`timescale 1ns/1ps
`default_nettype none

module complexCorrelator (
	input  logic clock,
	input  logic rst,
	input  logic advance,                                  // all stages step together
	input  mfPkg::complexSample inSample,
	input  logic inValid,
	input  mfPkg::complexSample coeffs [mfPkg::NUM_TAPS],
	output mfPkg::complexSample corrOut,
	output logic corrValid
);

	mfPkg::complexSample delayLine [mfPkg::NUM_TAPS];     // [0] newest
	mfPkg::complexSample window [mfPkg::NUM_TAPS];        // line as it will be after the shift

	// stage 1, conjugate sums per tap
	logic signed [mfPkg::TAP_SUM_WIDTH-1:0] sumReNext [mfPkg::NUM_TAPS];
	logic signed [mfPkg::TAP_SUM_WIDTH-1:0] sumImNext [mfPkg::NUM_TAPS];
	logic signed [mfPkg::TAP_SUM_WIDTH-1:0] sumRe [mfPkg::NUM_TAPS];
	logic signed [mfPkg::TAP_SUM_WIDTH-1:0] sumIm [mfPkg::NUM_TAPS];
	logic sumValid;
	logic take;                                            // sample accepted this cycle

	// stage 2, adder tree
	logic signed [mfPkg::ACC_WIDTH-1:0] halfRe [mfPkg::NUM_TAPS/2];
	logic signed [mfPkg::ACC_WIDTH-1:0] halfIm [mfPkg::NUM_TAPS/2];
	logic signed [mfPkg::ACC_WIDTH-1:0] quarterRe [mfPkg::NUM_TAPS/4];
	logic signed [mfPkg::ACC_WIDTH-1:0] quarterIm [mfPkg::NUM_TAPS/4];
	logic signed [mfPkg::ACC_WIDTH-1:0] accRe;
	logic signed [mfPkg::ACC_WIDTH-1:0] accIm;
	logic signed [mfPkg::ACC_WIDTH-1:0] shiftRe;
	logic signed [mfPkg::ACC_WIDTH-1:0] shiftIm;
	mfPkg::complexSample corrNext;

	assign take = advance && inValid;

	always_comb begin
		window[0] = inSample;
		for (int k = 1; k < mfPkg::NUM_TAPS; k++) begin
			window[k] = delayLine[k-1];
		end
	end

	// x * conj(c) = (xr*cr + xi*ci) + j(xi*cr - xr*ci)
	always_comb begin
		logic signed [mfPkg::PROD_WIDTH-1:0] rr;
		logic signed [mfPkg::PROD_WIDTH-1:0] ii;
		logic signed [mfPkg::PROD_WIDTH-1:0] ir;
		logic signed [mfPkg::PROD_WIDTH-1:0] ri;
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			rr = $signed(window[k].re) * $signed(coeffs[k].re);
			ii = $signed(window[k].im) * $signed(coeffs[k].im);
			ir = $signed(window[k].im) * $signed(coeffs[k].re);
			ri = $signed(window[k].re) * $signed(coeffs[k].im);
			sumReNext[k] = rr + ii;                        // one bit of growth
			sumImNext[k] = ir - ri;
		end
	end

	// control and delay line
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
				delayLine[k] <= '0;                        // old taps start at zero
			end
			sumValid <= 1'b0;
			corrValid <= 1'b0;
		end else if (advance) begin
			sumValid <= inValid;                           // bubbles travel as invalid
			corrValid <= sumValid;
			if (inValid) begin
				for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
					delayLine[k] <= window[k];
				end
			end
		end
	end

	// pairwise tree, three levels for eight taps
	always_comb begin
		for (int k = 0; k < mfPkg::NUM_TAPS / 2; k++) begin
			halfRe[k] = sumRe[2*k] + sumRe[2*k+1];        // sign extended to acc width
			halfIm[k] = sumIm[2*k] + sumIm[2*k+1];
		end
		for (int k = 0; k < mfPkg::NUM_TAPS / 4; k++) begin
			quarterRe[k] = halfRe[2*k] + halfRe[2*k+1];
			quarterIm[k] = halfIm[2*k] + halfIm[2*k+1];
		end
		accRe = quarterRe[0] + quarterRe[1];
		accIm = quarterIm[0] + quarterIm[1];
		shiftRe = accRe >>> mfPkg::OUT_SHIFT;               // sign kept
		shiftIm = accIm >>> mfPkg::OUT_SHIFT;
		corrNext.re = shiftRe[mfPkg::SAMPLE_WIDTH-1:0];     // plain truncation, wraps
		corrNext.im = shiftIm[mfPkg::SAMPLE_WIDTH-1:0];
	end

	// datapath registers
	always_ff @(posedge clock) begin
		if (take) begin
			for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
				sumRe[k] <= sumReNext[k];
				sumIm[k] <= sumImNext[k];
			end
		end
		if (advance) begin
			corrOut <= corrNext;
		end
	end

endmodule

`default_nettype wire

// ==== logic/matchedFilter.sv ====
`timescale 1ns/1ps
`default_nettype none

module matchedFilter (
	input  logic clock,
	input  logic rst,
	input  mfPkg::axiLiteReq axiReq,
	output mfPkg::axiLiteRsp axiRsp,
	input  mfPkg::complexSample inSample,
	input  logic inValid,
	output logic inReady,
	output logic [mfPkg::POWER_WIDTH-1:0] outPower,
	output logic outValid,
	input  logic outReady
);

	mfPkg::complexSample coeffs [mfPkg::NUM_TAPS];  // template, one clock behind the bank
	mfPkg::complexSample corrOut;
	logic corrValid;
	logic advance;                                  // pipeline step
	logic runEn;                                    // low in reset and the cycle after
	logic inTake;

	// last stage empty or being drained
	assign advance = !outValid || outReady;

	always_ff @(posedge clock) begin
		if (rst) begin
			runEn <= 1'b0;
		end else begin
			runEn <= 1'b1;
		end
	end

	assign inReady = advance && runEn;
	assign inTake = inValid && runEn;               // no sample sneaks in before ready

	mfCoeffRegs u_mfCoeffRegs (
		.clock  (clock),
		.rst    (rst),
		.axiReq (axiReq),
		.axiRsp (axiRsp),
		.coeffs (coeffs)
	);

	complexCorrelator u_complexCorrelator (
		.clock     (clock),
		.rst       (rst),
		.advance   (advance),
		.inSample  (inSample),
		.inValid   (inTake),
		.coeffs    (coeffs),
		.corrOut   (corrOut),
		.corrValid (corrValid)
	);

	powerDetect u_powerDetect (
		.clock     (clock),
		.rst       (rst),
		.advance   (advance),
		.corrOut   (corrOut),
		.corrValid (corrValid),
		.outPower  (outPower),
		.outValid  (outValid)
	);

endmodule

`default_nettype wire

// ==== logic/mfCoeffRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module mfCoeffRegs (
	input  logic clock,
	input  logic rst,
	input  mfPkg::axiLiteReq axiReq,
	output mfPkg::axiLiteRsp axiRsp,
	output mfPkg::complexSample coeffs [mfPkg::NUM_TAPS]
);

	mfPkg::regWord bank [mfPkg::NUM_TAPS]; // bus-side copy of the template

	// write channel state
	logic awReady;                          // shared by aw and w
	logic bValid;
	logic [1:0] bResp;
	logic wrFire;                           // aw and w handshake together
	logic wrHit;
	logic [mfPkg::ADDR_WIDTH-1:0] wrOffset;
	logic [mfPkg::TAP_IDX_WIDTH-1:0] wrIdx;

	// read channel state
	logic arReady;
	logic rValid;
	logic [1:0] rResp;
	logic [mfPkg::AXI_DATA_WIDTH-1:0] rData;
	logic rdFire;
	logic rdHit;
	logic idHit;
	logic [mfPkg::ADDR_WIDTH-1:0] rdOffset;
	logic [mfPkg::TAP_IDX_WIDTH-1:0] rdIdx;

	// byte lanes of the new data over the old word
	function automatic mfPkg::regWord mergeBytes(
		input mfPkg::regWord oldWord,
		input logic [mfPkg::AXI_DATA_WIDTH-1:0] data,
		input logic [mfPkg::AXI_STRB_WIDTH-1:0] strb
	);
		mfPkg::regWord merged;
		merged = oldWord;
		for (int b = 0; b < mfPkg::AXI_STRB_WIDTH; b++) begin
			if (strb[b]) begin
				merged.raw[8*b +: 8] = data[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// address decode
	// an address below the base wraps to a large offset and misses
	assign wrOffset = axiReq.awaddr - mfPkg::COEFF_BASE;
	assign wrHit = (wrOffset < mfPkg::COEFF_SPAN) && (wrOffset[1:0] == 2'b00);
	assign wrIdx = wrOffset[mfPkg::TAP_IDX_WIDTH+1:2];  // word index

	assign rdOffset = axiReq.araddr - mfPkg::COEFF_BASE;
	assign rdHit = (rdOffset < mfPkg::COEFF_SPAN) && (rdOffset[1:0] == 2'b00);
	assign rdIdx = rdOffset[mfPkg::TAP_IDX_WIDTH+1:2];
	assign idHit = (axiReq.araddr == mfPkg::ID_ADDR);   // identity is read only

	assign wrFire = awReady && axiReq.awvalid && axiReq.wvalid;
	assign rdFire = arReady && axiReq.arvalid;

	// write FSM, one transaction outstanding
	always_ff @(posedge clock) begin
		if (rst) begin
			awReady <= 1'b0;
			bValid <= 1'b0;
			for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
				bank[k] <= '0;
			end
		end else begin
			awReady <= 1'b0;                            // ready is a single pulse
			if (wrFire) begin
				bValid <= 1'b1;
				if (wrHit) begin
					bank[wrIdx] <= mergeBytes(bank[wrIdx], axiReq.wdata, axiReq.wstrb);
				end
			end else if (bValid) begin
				if (axiReq.bready) begin
					bValid <= 1'b0;                     // response taken
				end
			end else if (axiReq.awvalid && axiReq.wvalid) begin
				awReady <= 1'b1;                        // need both before accepting
			end
		end
	end

	// read FSM
	always_ff @(posedge clock) begin
		if (rst) begin
			arReady <= 1'b0;
			rValid <= 1'b0;
		end else begin
			arReady <= 1'b0;
			if (rdFire) begin
				rValid <= 1'b1;
			end else if (rValid) begin
				if (axiReq.rready) begin
					rValid <= 1'b0;
				end
			end else if (axiReq.arvalid) begin
				arReady <= 1'b1;
			end
		end
	end

	// response payloads
	always_ff @(posedge clock) begin
		if (wrFire) begin
			bResp <= wrHit ? mfPkg::RESP_OKAY : mfPkg::RESP_SLVERR;
		end
		if (rdFire) begin
			if (rdHit) begin
				rData <= bank[rdIdx].raw;
				rResp <= mfPkg::RESP_OKAY;
			end else if (idHit) begin
				rData <= mfPkg::ID_VALUE;
				rResp <= mfPkg::RESP_OKAY;
			end else begin
				rData <= '0;                            // unmapped reads return zero
				rResp <= mfPkg::RESP_SLVERR;
			end
		end
	end

	// second register stage toward the datapath, complex view of each word
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
				coeffs[k] <= '0;
			end
		end else begin
			for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
				coeffs[k] <= bank[k].cplx;
			end
		end
	end

	assign axiRsp = '{
		awready: awReady,
		wready: awReady,
		bresp: bResp,
		bvalid: bValid,
		arready: arReady,
		rdata: rData,
		rresp: rResp,
		rvalid: rValid
	};

endmodule

`default_nettype wire

// ==== logic/mfPkg.sv ====
`default_nettype none

package mfPkg;

	// datapath sizing
	localparam int NUM_TAPS = 8;                        // taps and coefficient words
	localparam int SAMPLE_WIDTH = 16;                   // one real or imaginary part
	localparam int PROD_WIDTH = 2 * SAMPLE_WIDTH;       // one real product
	localparam int TAP_SUM_WIDTH = PROD_WIDTH + 1;      // two products summed per tap
	localparam int ACC_WIDTH = 36;                      // full precision over all taps
	localparam int OUT_SHIFT = 15;                      // back to sample scale
	localparam int POWER_WIDTH = 33;                    // re^2 + im^2, unsigned
	localparam int TAP_IDX_WIDTH = $clog2(NUM_TAPS);

	// register map, byte addresses
	localparam int ADDR_WIDTH = 6;
	localparam int AXI_DATA_WIDTH = 32;
	localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
	localparam logic [ADDR_WIDTH-1:0] COEFF_BASE = 6'd0;           // coefficient 0
	localparam logic [ADDR_WIDTH-1:0] COEFF_SPAN = 6'(4 * NUM_TAPS); // bytes in the bank
	localparam logic [ADDR_WIDTH-1:0] ID_ADDR = 6'd32;             // read-only identity
	localparam logic [AXI_DATA_WIDTH-1:0] ID_VALUE = 32'h6D66_0008; // "mf", 8 taps

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// one complex value, re in the upper half
	typedef struct packed {
		logic signed [SAMPLE_WIDTH-1:0] re;
		logic signed [SAMPLE_WIDTH-1:0] im;
	} complexSample;

	// bus word seen raw by the bus side, complex by the correlator
	typedef union packed {
		logic [AXI_DATA_WIDTH-1:0] raw;
		complexSample cplx;
	} regWord;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] awaddr;
		logic awvalid;
		logic [AXI_DATA_WIDTH-1:0] wdata;
		logic [AXI_STRB_WIDTH-1:0] wstrb;
		logic wvalid;
		logic bready;
		logic [ADDR_WIDTH-1:0] araddr;
		logic arvalid;
		logic rready;
	} axiLiteReq;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [AXI_DATA_WIDTH-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiLiteRsp;

endpackage

`default_nettype wire

// ==== logic/powerDetect.sv ====
`timescale 1ns/1ps
`default_nettype none

module powerDetect (
	input  logic clock,
	input  logic rst,
	input  logic advance,
	input  mfPkg::complexSample corrOut,
	input  logic corrValid,
	output logic [mfPkg::POWER_WIDTH-1:0] outPower,
	output logic outValid                             // also tells the top this slot is full
);

	logic [mfPkg::PROD_WIDTH-1:0] reSq;               // square is never negative
	logic [mfPkg::PROD_WIDTH-1:0] imSq;
	logic [mfPkg::POWER_WIDTH-1:0] powerNext;

	always_comb begin
		reSq = $signed(corrOut.re) * $signed(corrOut.re);
		imSq = $signed(corrOut.im) * $signed(corrOut.im);
		powerNext = reSq + imSq;                      // carry lands in the top bit
	end

	// valid flag
	always_ff @(posedge clock) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= corrValid;
		end
	end

	// held while stalled
	always_ff @(posedge clock) begin
		if (advance) begin
			outPower <= powerNext;
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/mfPkg.sv
logic/mfCoeffRegs.sv
logic/complexCorrelator.sv
logic/powerDetect.sv
logic/matchedFilter.sv
tests/matchedFilter_assert.sv
tests/matchedFilterTb.sv

// ==== tests/matchedFilterTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module matchedFilterTb;

	typedef enum logic [1:0] {REG_ACCESS, STREAM, COEFF_UPDATE} testKind;

	typedef struct packed {
		testKind kind;
		logic randomSet;                                   // else impulse template and sample
		logic [7:0] count;                                 // samples in the row
		logic backPressure;                                // random outReady and bubbles
		logic handChecked;
		logic [mfPkg::NUM_TAPS-1:0][mfPkg::POWER_WIDTH-1:0] hand; // first outputs, [0] first
	} stimRow;

	logic clock;
	logic rst;
	mfPkg::axiLiteReq axiReq;
	mfPkg::axiLiteRsp axiRsp;
	mfPkg::complexSample inSample;
	logic inValid;
	logic inReady;
	logic [mfPkg::POWER_WIDTH-1:0] outPower;
	logic outValid;
	logic outReady;

	stimRow stimTable [5];
	logic tableReady;
	logic [31:0] lfsrState;
	mfPkg::regWord modelBank [mfPkg::NUM_TAPS];           // template the DUT should hold
	mfPkg::complexSample modelLine [mfPkg::NUM_TAPS];     // [0] newest
	logic [mfPkg::POWER_WIDTH-1:0] expQ [$];              // powers still owed by the DUT

	matchedFilter u_matchedFilter (.clock(clock), .rst(rst), .axiReq(axiReq), .axiRsp(axiRsp),
		.inSample(inSample), .inValid(inValid), .inReady(inReady), .outPower(outPower),
		.outValid(outValid), .outReady(outReady));

	bind matchedFilter matchedFilter_assert u_matchedFilterAssert (.*);

	always #10 clock = ~clock;

	task automatic abortRun();
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] want);
		if (got !== want) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
			abortRun();
		end
	endtask

	task automatic checkWord(input string name, input mfPkg::regWord got,
			input mfPkg::regWord want);
		if (got.raw !== want.raw) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got.raw, want.raw);
			abortRun();
		end
	endtask

	task automatic checkPower(input string name, input logic [mfPkg::POWER_WIDTH-1:0] got,
			input logic [mfPkg::POWER_WIDTH-1:0] want);
		if (got !== want) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
			abortRun();
		end
	endtask

	// Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
		end
		return bits;
	endfunction

	task automatic countWait(input string what, inout int waited);
		waited++;
		if (waited > 32) begin
			$display("no %s from the DUT within 32 cycles", what);
			abortRun();
		end
	endtask

	task automatic axiWrite(input logic [mfPkg::ADDR_WIDTH-1:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int waited;
		waited = 0;
		@(negedge clock);
		axiReq.awaddr = addr;
		axiReq.wdata = data;
		axiReq.wstrb = strb;
		axiReq.awvalid = 1'b1;
		axiReq.wvalid = 1'b1;
		while (!(axiRsp.awready && axiRsp.wready)) begin
			@(negedge clock);
			countWait("awready and wready", waited);
		end
		@(negedge clock);                                  // taken on the edge just passed
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		while (!axiRsp.bvalid) begin
			@(negedge clock);
			countWait("bvalid", waited);
		end
		@(negedge clock);                                  // bready late so bvalid has to hold
		resp = axiRsp.bresp;
		axiReq.bready = 1'b1;
		@(negedge clock);
		axiReq.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [mfPkg::ADDR_WIDTH-1:0] addr, output mfPkg::regWord data,
			output logic [1:0] resp);
		int waited;
		waited = 0;
		@(negedge clock);
		axiReq.araddr = addr;
		axiReq.arvalid = 1'b1;
		while (!axiRsp.arready) begin
			@(negedge clock);
			countWait("arready", waited);
		end
		@(negedge clock);
		axiReq.arvalid = 1'b0;
		while (!axiRsp.rvalid) begin
			@(negedge clock);
			countWait("rvalid", waited);
		end
		data.raw = axiRsp.rdata;
		resp = axiRsp.rresp;
		axiReq.rready = 1'b1;
		@(negedge clock);
		axiReq.rready = 1'b0;
	endtask

	// model sees the new word once the response is back
	task automatic writeCoeff(input int idx, input logic [31:0] data, input logic [3:0] strb);
		logic [1:0] resp;
		axiWrite(mfPkg::COEFF_BASE + 6'(4 * idx), data, strb, resp);
		checkResp("bresp", resp, mfPkg::RESP_OKAY);
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				modelBank[idx].raw[8*b +: 8] = data[8*b +: 8];
			end
		end
	endtask

	task automatic readBank();
		mfPkg::regWord got;
		logic [1:0] resp;
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			axiRead(mfPkg::COEFF_BASE + 6'(4 * k), got, resp);
			checkResp("rresp", resp, mfPkg::RESP_OKAY);
			checkWord("rdata", got, modelBank[k]);
		end
	endtask

	task automatic checkRegisters();
		logic [5:0] badAddr [3] = '{6'd36, mfPkg::ID_ADDR, 6'd6}; // past the bank, identity, odd
		mfPkg::regWord got;
		mfPkg::regWord want;
		logic [1:0] resp;
		logic [31:0] word;
		logic [3:0] strb;
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			writeCoeff(k, takeBits(32), 4'hF);
			word = takeBits(32);
			strb = 4'(takeBits(4));                        // some lanes only
			writeCoeff(k, word, strb);
		end
		readBank();
		axiRead(mfPkg::ID_ADDR, got, resp);
		want.raw = mfPkg::ID_VALUE;
		checkResp("rresp", resp, mfPkg::RESP_OKAY);
		checkWord("rdata", got, want);
		foreach (badAddr[i]) begin
			axiWrite(badAddr[i], 32'hDEAD_BEEF, 4'hF, resp);
			checkResp("bresp", resp, mfPkg::RESP_SLVERR);
		end
		axiRead(6'd40, got, resp);
		want.raw = '0;
		checkResp("rresp", resp, mfPkg::RESP_SLVERR);
		checkWord("rdata", got, want);
		readBank();                                        // bank untouched by the misses
	endtask

	// x * conj(c) summed over the taps, scaled, truncated, then squared
	function automatic logic [mfPkg::POWER_WIDTH-1:0] expectedPower();
		longint accRe;
		longint accIm;
		longint xr;
		longint xi;
		longint cr;
		longint ci;
		logic signed [mfPkg::SAMPLE_WIDTH-1:0] re;
		logic signed [mfPkg::SAMPLE_WIDTH-1:0] im;
		longint power;
		accRe = 0;
		accIm = 0;
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			xr = $signed(modelLine[k].re);
			xi = $signed(modelLine[k].im);
			cr = $signed(modelBank[k].cplx.re);
			ci = $signed(modelBank[k].cplx.im);
			accRe += xr * cr + xi * ci;
			accIm += xi * cr - xr * ci;
		end
		accRe = accRe >>> mfPkg::OUT_SHIFT;
		accIm = accIm >>> mfPkg::OUT_SHIFT;
		re = accRe[mfPkg::SAMPLE_WIDTH-1:0];
		im = accIm[mfPkg::SAMPLE_WIDTH-1:0];
		power = longint'(re) * re + longint'(im) * im;
		return power[mfPkg::POWER_WIDTH-1:0];
	endfunction

	task automatic acceptSample(input mfPkg::complexSample s);
		for (int k = mfPkg::NUM_TAPS - 1; k > 0; k--) begin
			modelLine[k] = modelLine[k-1];
		end
		modelLine[0] = s;
		expQ.push_back(expectedPower());
	endtask

	function automatic mfPkg::complexSample nextSample(input int row, input int idx);
		mfPkg::complexSample s;
		if (stimTable[row].randomSet) begin
			s = takeBits(32);
		end else begin
			s = (idx == 0) ? {16'sd32767, 16'sd0} : '0;    // lone impulse, then silence
		end
		return s;
	endfunction

	task automatic loadTemplate(input int row);
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			if (stimTable[row].randomSet) begin
				writeCoeff(k, takeBits(32), 4'hF);
			end else begin
				writeCoeff(k, {16'(8192 * (k + 1)), 16'h0}, 4'hF); // wraps past 32767 from k=3
			end
		end
	endtask

	task automatic runStream(input int row, input int count, input logic drain);
		int sent;
		int seen;
		mfPkg::complexSample next;
		logic [mfPkg::POWER_WIDTH-1:0] want;
		sent = 0;
		seen = 0;
		next = nextSample(row, 0);
		while (sent < count || (drain && expQ.size() > 0)) begin
			@(negedge clock);
			inSample = next;
			inValid = (sent < count) && (!stimTable[row].backPressure || takeBits(1) != 0);
			outReady = !stimTable[row].backPressure || takeBits(1) != 0;
			#1;                                            // settled until the next rising edge
			if (outValid && outReady) begin
				if (expQ.size() == 0) begin
					$display("the DUT gave an output that no accepted sample accounts for");
					abortRun();
				end
				want = expQ.pop_front();
				checkPower("outPower", outPower, want);
				if (stimTable[row].handChecked && seen < mfPkg::NUM_TAPS) begin
					checkPower("outPower", outPower, stimTable[row].hand[seen]);
				end
				seen++;
			end
			if (outValid && !outReady && inReady) begin
				$display("inReady stayed high while a result was held");
				abortRun();
			end
			if (inValid && inReady) begin
				acceptSample(inSample);
				sent++;
				next = nextSample(row, sent);
			end
		end
		@(negedge clock);
		inValid = 1'b0;
		outReady = 1'b0;                                   // leftovers wait in the pipeline
	endtask

	initial begin
		longint budget;
		wait (tableReady);
		budget = 2000;                                     // AXI traffic and drain
		foreach (stimTable[row]) begin
			budget += 4 * stimTable[row].count;
		end
		#(budget * 20);
		$display("watchdog expired, the DUT stopped making progress");
		abortRun();
	end

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		axiReq = '0;
		inSample = '0;
		inValid = 1'b0;
		outReady = 1'b0;
		lfsrState = 32'h6897_244f;
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			modelBank[k] = '0;
			modelLine[k] = '0;
		end
		stimTable[0] = '{kind: REG_ACCESS, randomSet: 1'b1, count: 8'd0, backPressure: 1'b0,
			handChecked: 1'b0, hand: '0};
		stimTable[1] = '{kind: STREAM, randomSet: 1'b0, count: 8'd10, backPressure: 1'b0,
			handChecked: 1'b1, hand: {33'd0, 33'd67108864, 33'd268435456, 33'd603979776,
			33'd1073676289, 33'd603930625, 33'd268402689, 33'd67092481}};
		stimTable[2] = '{kind: STREAM, randomSet: 1'b1, count: 8'd40, backPressure: 1'b0,
			handChecked: 1'b0, hand: '0};
		stimTable[3] = '{kind: STREAM, randomSet: 1'b1, count: 8'd40, backPressure: 1'b1,
			handChecked: 1'b0, hand: '0};
		stimTable[4] = '{kind: COEFF_UPDATE, randomSet: 1'b1, count: 8'd24, backPressure: 1'b1,
			handChecked: 1'b0, hand: '0};
		tableReady = 1'b1;
		repeat (4) @(negedge clock);
		rst = 1'b0;
		foreach (stimTable[row]) begin
			case (stimTable[row].kind)
				REG_ACCESS: checkRegisters();
				STREAM: begin
					loadTemplate(row);
					runStream(row, stimTable[row].count, 1'b1);
				end
				default: begin
					loadTemplate(row);
					runStream(row, stimTable[row].count / 2, 1'b0); // results stalled in flight
					writeCoeff(3, takeBits(32), 4'hF);
					runStream(row, stimTable[row].count - stimTable[row].count / 2, 1'b1);
				end
			endcase
		end
		outReady = 1'b1;
		repeat (6) begin
			@(negedge clock);
			if (outValid) begin
				$display("the DUT gave an extra output after the last sample");
				abortRun();
			end
		end
		if (u_matchedFilter.u_matchedFilterAssert.failCount == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			abortRun();
		end
	end

endmodule

`default_nettype wire

// ==== tests/matchedFilter_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module matchedFilter_assert (
	input logic clock,
	input logic rst,
	input mfPkg::axiLiteReq axiReq,
	input mfPkg::axiLiteRsp axiRsp,
	input logic inReady,
	input logic [mfPkg::POWER_WIDTH-1:0] outPower,
	input logic outValid,
	input logic outReady
);

	int failCount = 0;                                     // read by the testbench at the end

	outHeld: assert property (@(posedge clock) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(outPower))
		else begin $error("result dropped or changed while outReady was low"); failCount++; end

	bHeld: assert property (@(posedge clock) disable iff (rst)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid && $stable(axiRsp.bresp))
		else begin $error("write response withdrawn before bready"); failCount++; end

	rHeld: assert property (@(posedge clock) disable iff (rst)
		axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid && $stable(axiRsp.rdata))
		else begin $error("read data withdrawn before rready"); failCount++; end

	// first edge of reset still has registers unknown
	readyInReset: assert property (@(posedge clock) rst && $past(rst) |-> !inReady)
		else begin $error("inReady high during reset"); failCount++; end

	validAfterReset: assert property (@(posedge clock) $fell(rst) |-> !outValid)
		else begin $error("outValid high right after reset"); failCount++; end

endmodule

`default_nettype wire
